/* all.f */
src/mul_types_pkg.sv
src/mul_stage_pkg.sv
src/pp_seed_stage.sv
src/cs_row_stage.sv
src/final_cpa_stage.sv
src/array_mul_top.sv
verification/array_mul_tb.sv

/* run_sim.sh */
#!/bin/sh
# builds the multiplier testbench with Verilator, runs it, checks the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=array_mul_sim
log_file=sim.log

if ! command -v verilator >/dev/null 2>&1; then
    echo "verilator not found in PATH"
    exit 1
fi

verilator --binary --timing --assert \
    --top-module array_mul_tb \
    -f all.f \
    --Mdir "$build_dir" \
    -o "$sim_bin"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
status=$?
cat "$log_file"
if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
    echo "simulation reported a failure, see $log_file"
    exit 1
fi

echo "simulation finished without failures"
exit 0

/* verification/array_mul_tb.sv */
`timescale 1ns/1ns

module array_mul_tb;

   import mul_types_pkg::*;

   // operands as the DUT took them on one edge
   typedef struct packed {
      operand_t a;
      operand_t b;
   } op_pair_t;

   localparam int clk_period = 4;
   // spare edges a wait may use beyond the ranks it waits for
   localparam int wait_margin = 8;

   logic     clk;
   logic     rst_n;
   operand_t a;
   operand_t b;
   product_t product;

   integer   seed;
   int       value_errors = 0;
   int       timeout_errors = 0;
   // edges taken while out of reset
   int       ranks_advanced = 0;

   // operand pairs in flight with slot 0 taken on the last edge
   op_pair_t in_flight [0:pipe_latency-1];
   op_pair_t oldest;
   product_t expected;

   array_mul_top array_mul_top_i (
      .clk     (clk),
      .rst_n   (rst_n),
      .a       (a),
      .b       (b),
      .product (product)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clk_period / 2) clk = ~clk;
      end
   end

   // follows the operands through as many ranks as the DUT has
   always @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int k = 0; k < pipe_latency; k++) begin
            in_flight[k] <= '0;
         end
      end else begin
         in_flight[0] <= {a, b};
         for (int k = 1; k < pipe_latency; k++) begin
            in_flight[k] <= in_flight[k-1];
         end
         ranks_advanced <= ranks_advanced + 1;
      end
   end

   assign oldest = in_flight[pipe_latency-1];

   // unsigned product of the pair at full width
   assign expected = product_t'(oldest.a) * product_t'(oldest.b);

   a_product_value: assert property (
      @(posedge clk) product == expected
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected %0d actual %0d",
               $time, $sampled(expected), $sampled(product));
   end

   a_reset_clears: assert property (
      @(posedge clk) !rst_n |-> product == '0
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected 0 actual %0d during reset",
               $time, $sampled(product));
   end

   // all ones on both sides drives every carry path and leaves no carry out
   a_largest: assert property (
      @(posedge clk) (oldest.a == '1 && oldest.b == '1) |-> product == product_t'(261121)
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected 261121 actual %0d",
               $time, $sampled(product));
   end

   a_zero_operand: assert property (
      @(posedge clk) (oldest.a == '0 || oldest.b == '0) |-> product == '0
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected 0 actual %0d", $time, $sampled(product));
   end

   a_identity_a: assert property (
      @(posedge clk) oldest.a == operand_t'(1) |-> product == product_t'(oldest.b)
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected %0d actual %0d",
               $time, $sampled(oldest.b), $sampled(product));
   end

   a_identity_b: assert property (
      @(posedge clk) oldest.b == operand_t'(1) |-> product == product_t'(oldest.a)
   ) else begin
      value_errors++;
      $display("ERR t=%0t product expected %0d actual %0d",
               $time, $sampled(oldest.a), $sampled(product));
   end

   task automatic apply_operands(input operand_t a_val, input operand_t b_val);
      @(posedge clk);
      a <= a_val;
      b <= b_val;
   endtask

   task automatic apply_random(input int count);
      for (int i = 0; i < count; i++) begin
         apply_operands(operand_t'($random(seed)), operand_t'($random(seed)));
      end
   endtask

   // returns once the pipeline has moved n ranks out of reset
   task automatic wait_ranks(input int n, input string what);
      int target;
      int guard;
      target = ranks_advanced + n;
      guard = 0;
      while (ranks_advanced < target && guard < n + wait_margin) begin
         @(posedge clk);
         guard++;
      end
      if (ranks_advanced < target) begin
         timeout_errors++;
         $display("timeout while %s: pipeline moved %0d of %0d ranks",
                  what, n - (target - ranks_advanced), n);
      end
   endtask

   task automatic pulse_reset(input int cycles);
      @(posedge clk);
      rst_n <= 1'b0;
      repeat (cycles) @(posedge clk);
      rst_n <= 1'b1;
   endtask

   initial begin
      seed = 74;
      rst_n <= 1'b0;
      a <= '0;
      b <= '0;

      // zero operands right after release keep product at zero
      repeat (2) @(posedge clk);
      rst_n <= 1'b1;
      wait_ranks(pipe_latency + 1, "flushing after reset");

      apply_random(300);

      apply_operands('1, '1);
      apply_operands('1, '1);

      for (int i = 0; i < 8; i++) begin
         apply_operands(operand_t'($random(seed)), '0);
         apply_operands('0, operand_t'($random(seed)));
      end

      for (int i = 0; i < 8; i++) begin
         apply_operands(operand_t'(1), operand_t'($random(seed)));
         apply_operands(operand_t'($random(seed)), operand_t'(1));
      end
      apply_operands(operand_t'(1), operand_t'(1));

      apply_operands('0, '0);
      wait_ranks(pipe_latency + 1, "draining directed operands");

      // products in flight when reset hits
      apply_random(20);
      pulse_reset(2);
      apply_random(40);
      apply_operands('0, '0);
      wait_ranks(pipe_latency + 1, "draining after reset in flight");

      $display("value errors: %0d, timeouts: %0d", value_errors, timeout_errors);
      if (value_errors == 0 && timeout_errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

/* src/array_mul_top.sv */
`timescale 1ns/1ns

module array_mul_top (
   input  logic                    clk,
   input  logic                    rst_n,
   input  mul_types_pkg::operand_t a,
   input  mul_types_pkg::operand_t b,
   output mul_types_pkg::product_t product
);

   import mul_types_pkg::*;
   import mul_stage_pkg::*;

   cs_stage_t seed_stage;
   // entry k is the record leaving row k, entry 0 the seed
   cs_stage_t row_stage [0:op_width-1];

   pp_seed_stage pp_seed_stage_i (
      .clk       (clk),
      .rst_n     (rst_n),
      .a         (a),
      .b         (b),
      .stage_out (seed_stage)
   );

   assign row_stage[0] = seed_stage;

   // one carry-save row per multiplier bit above bit 0
   for (genvar k = 1; k < op_width; k++) begin : g_row
      cs_row_stage #(
         .row_index (k)
      ) cs_row_stage_i (
         .clk       (clk),
         .rst_n     (rst_n),
         .stage_in  (row_stage[k-1]),
         .stage_out (row_stage[k])
      );
   end

   final_cpa_stage final_cpa_stage_i (
      .clk      (clk),
      .rst_n    (rst_n),
      .stage_in (row_stage[op_width-1]),
      .product  (product)
   );

   // end to end, any reset in between drops the attempt
   a_pipe_latency: assert property (
      @(posedge clk) disable iff (!rst_n)
      1'b1 |-> ##pipe_latency
         (product == product_t'($past(a, pipe_latency)) * product_t'($past(b, pipe_latency)))
   ) else $error("product does not match operands taken %0d cycles earlier", pipe_latency);

endmodule

/* src/final_cpa_stage.sv */
`timescale 1ns/1ns

module final_cpa_stage (
   input  logic                     clk,
   input  logic                     rst_n,
   input  mul_stage_pkg::cs_stage_t stage_in,
   output mul_types_pkg::product_t  product
);

   import mul_types_pkg::*;
   import mul_stage_pkg::*;

   // sums lined up with the carries
   row_vec_t          sum_aligned;
   row_vec_t          upper_bits;
   logic [op_width:0] ripple_c;
   product_t          product_next;

   // sum bit 0 already lives in low_bits
   assign sum_aligned = {1'b0, stage_in.sum[op_width-1:1]};

   // plain ripple chain, lsb first
   always_comb begin
      ripple_c[0] = 1'b0;
      for (int j = 0; j < op_width; j++) begin
         upper_bits[j] = sum_aligned[j] ^ stage_in.carry[j] ^ ripple_c[j];
         ripple_c[j+1] = (sum_aligned[j] & stage_in.carry[j])
                       | (ripple_c[j] & (sum_aligned[j] ^ stage_in.carry[j]));
      end
   end

   // lower half was settled row by row on the way down
   assign product_next = {upper_bits, stage_in.low_bits};

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         product <= '0;
      end else begin
         product <= product_next;
      end
   end

   // the whole array must leave nothing beyond the top product bit
   a_no_overflow: assert property (
      @(posedge clk) disable iff (!rst_n)
      ripple_c[op_width] == 1'b0
   ) else $error("final adder carried out past bit %0d", prod_width - 1);

endmodule

/* src/cs_row_stage.sv */
`timescale 1ns/1ns

module cs_row_stage #(
   parameter int row_index = 1
) (
   input  logic                     clk,
   input  logic                     rst_n,
   input  mul_stage_pkg::cs_stage_t stage_in,
   output mul_stage_pkg::cs_stage_t stage_out
);

   import mul_types_pkg::*;
   import mul_stage_pkg::*;

   // partial product of this row
   row_vec_t  pp_row;
   // incoming sums moved onto this row's columns
   row_vec_t  sum_above;
   row_vec_t  row_sum;
   row_vec_t  row_carry;
   cs_stage_t stage_next;

   // row 0 belongs to the seed stage, and the top bit has no row after it
   initial begin
      assert (row_index >= 1 && row_index < op_width)
         else $fatal(1, "row_index %0d outside 1..%0d", row_index, op_width - 1);
   end

   assign pp_row = stage_in.a & {op_width{stage_in.b[row_index]}};

   // top column has nothing above it
   assign sum_above = {1'b0, stage_in.sum[op_width-1:1]};

   // one full adder per column
   assign row_sum = pp_row ^ sum_above ^ stage_in.carry;
   assign row_carry = (pp_row & sum_above)
                    | (stage_in.carry & (pp_row ^ sum_above));

   always_comb begin
      stage_next = stage_in;
      stage_next.sum = row_sum;
      stage_next.carry = row_carry;
      // column 0 of this row is the next settled product bit
      stage_next.low_bits[row_index] = row_sum[0];
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage_out <= '0;
      end else begin
         stage_out <= stage_next;
      end
   end

   // operands must stay paired with their partial sums along the whole chain
   a_operands_follow: assert property (
      @(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         (stage_out.a == $past(stage_in.a) && stage_out.b == $past(stage_in.b))
   ) else $error("row %0d operands changed between ranks", row_index);

   // bits settled by earlier rows are never touched again
   a_low_bits_kept: assert property (
      @(posedge clk) disable iff (!rst_n)
      $past(rst_n) |->
         (stage_out.low_bits[row_index-1:0] == $past(stage_in.low_bits[row_index-1:0]))
   ) else $error("row %0d disturbed settled low product bits", row_index);

endmodule

/* src/pp_seed_stage.sv */
`timescale 1ns/1ns

module pp_seed_stage (
   input  logic                     clk,
   input  logic                     rst_n,
   input  mul_types_pkg::operand_t  a,
   input  mul_types_pkg::operand_t  b,
   output mul_stage_pkg::cs_stage_t stage_out
);

   import mul_types_pkg::*;
   import mul_stage_pkg::*;

   row_vec_t  pp_row;
   cs_stage_t stage_next;

   // row 0 of the array, a gated by b[0]
   assign pp_row = a & {op_width{b[0]}};

   always_comb begin
      stage_next = '0;
      stage_next.a = a;
      stage_next.b = b;
      // product bit 0 is final straight away
      stage_next.low_bits[0] = pp_row[0];
      // higher bits wait for row 1
      stage_next.sum = {pp_row[op_width-1:1], 1'b0};
      // nothing has been added yet, so no carries
      stage_next.carry = '0;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         stage_out <= '0;
      end else begin
         stage_out <= stage_next;
      end
   end

endmodule

/* src/mul_stage_pkg.sv */
package mul_stage_pkg;

   import mul_types_pkg::*;

   // one bit per array column
   typedef logic [op_width-1:0] row_vec_t;

   // record handed from one pipeline rank to the next
   typedef struct packed {
      // operands ride along so every row sees its own pair
      operand_t a;
      operand_t b;
      // bit 0 sits on the column that is already settled in low_bits
      row_vec_t sum;
      // carry bit j weighs the same as sum bit j+1
      row_vec_t carry;
      // settled product bits, valid up to the producing row
      row_vec_t low_bits;
   } cs_stage_t;

endpackage

/* src/mul_types_pkg.sv */
package mul_types_pkg;

   // operand width; the array, the records and the latency all scale from it
   localparam int op_width = 9;

   // full product width
   localparam int prod_width = 2 * op_width;

   // seed rank, one rank per carry-save row, then the product rank
   localparam int pipe_latency = op_width + 1;

   // unsigned multiplicand and multiplier
   typedef logic [op_width-1:0] operand_t;

   // unsigned product, never wider than both operands together
   typedef logic [prod_width-1:0] product_t;

endpackage
